/* sim.f */
verilog/sfp_test_pkg.sv
verilog/send_scheduler.sv
verilog/expander_sequencer.sv
verilog/health_indicator.sv
verilog/sfp_test_top.sv
verif/sfp_test_asserts.sv
verif/tb_sfp_test.sv

/* verif/sfp_test_asserts.sv */
`timescale 1ns/100ps

module sfp_test_asserts
(
    input logic clk_50_pll,
    input logic rst_n,
    input logic dev_ready_i,
    input logic need_write_reg_o_i,
    input logic need_read_reg_i_i,
    input logic need_read_reg_o_i,
    input logic cmd_send_1_i,
    input logic cmd_send_2_i
);

int          error_cnt = 0;
logic [2:0]  req;

assign req = {need_write_reg_o_i, need_read_reg_i_i, need_read_reg_o_i};

one_request_a : assert property (@(posedge clk_50_pll) disable iff (!rst_n)
    $onehot0(req))
else
begin
    $error("more than one expander request active");
    error_cnt = error_cnt + 1;
end

// a request only rises from a ready engine
rise_on_ready_a : assert property (@(posedge clk_50_pll) disable iff (!rst_n)
    (|(req & ~$past(req))) |-> dev_ready_i)
else
begin
    $error("expander request rose while engine busy");
    error_cnt = error_cnt + 1;
end

send_excl_a : assert property (@(posedge clk_50_pll) disable iff (!rst_n)
    !(cmd_send_1_i && cmd_send_2_i))
else
begin
    $error("both send strobes high");
    error_cnt = error_cnt + 1;
end

endmodule

bind send_scheduler sfp_test_asserts i_send_asserts
(
    .clk_50_pll         (clk_50_pll),
    .rst_n              (rst_n),
    .dev_ready_i        (1'b1),
    .need_write_reg_o_i (1'b0),
    .need_read_reg_i_i  (1'b0),
    .need_read_reg_o_i  (1'b0),
    .cmd_send_1_i       (cmd_send_1_o),
    .cmd_send_2_i       (cmd_send_2_o)
);

bind expander_sequencer sfp_test_asserts i_seq_asserts
(
    .clk_50_pll         (clk_50_pll),
    .rst_n              (rst_n),
    .dev_ready_i        (dev_ready_i),
    .need_write_reg_o_i (need_write_reg_o_o),
    .need_read_reg_i_i  (need_read_reg_i_o),
    .need_read_reg_o_i  (need_read_reg_o_o),
    .cmd_send_1_i       (1'b0),
    .cmd_send_2_i       (1'b0)
);

/* verif/tb_sfp_test.sv */
`timescale 1ns/100ps

module tb_sfp_test;

localparam int SP1       = 20;
localparam int SP2       = 40;
localparam int BLINK_T   = 60;
localparam int RELAX_T   = 15;
localparam int BLINK_DIV = 8;
localparam int ROUND     = SP2 + 10;
localparam logic [31:0] SEED = 32'h7fbc_6751;
// three access rounds and three scheduler rounds, doubled, plus reset
localparam int CYCLE_LIMIT = 2 * (3 * (BLINK_T + 2 * RELAX_T + 3 * 13) + 3 * ROUND) + 8;

logic clk_50_pll;
logic rst_n;
logic mac_inited;
logic rx_ready;
logic dev_ready;
logic need_write_reg_o;
logic need_read_reg_i;
logic need_read_reg_o;
logic cmd_send_1;
logic cmd_send_2;
logic sfp_gled;
logic sfp_rled;
logic sfp_txflt_led;
logic sfp_rlos_led;
logic blink_led;

int          cycle_cnt    = 0;   // edges since reset release
int          run_cycles   = 0;
int          en_cnt       = 0;   // enabled scheduler edges
int          op_cnt       = 0;
int          rounds_done  = 0;
int          done_cycle   = 0;
int          gled_toggles = 0;
logic        gled_prev    = 1'b1;
logic        mac_prev     = 1'b0;
logic        rx_prev      = 1'b0;
logic [31:0] eng_rng      = SEED;
logic [31:0] stim_rng     = SEED;

sfp_test_top #(
    .SEND_PERIOD_1      (SP1),
    .SEND_PERIOD_2      (SP2),
    .BLINK_TIME         (BLINK_T),
    .RELAX_TIME         (RELAX_T),
    .BLINK_DIVIDE       (BLINK_DIV)
) i_dut (
    .clk_50_pll         (clk_50_pll),
    .rst_n              (rst_n),
    .mac_inited_i       (mac_inited),
    .rx_ready_i         (rx_ready),
    .dev_ready_i        (dev_ready),
    .need_write_reg_o_o (need_write_reg_o),
    .need_read_reg_i_o  (need_read_reg_i),
    .need_read_reg_o_o  (need_read_reg_o),
    .cmd_send_1_o       (cmd_send_1),
    .cmd_send_2_o       (cmd_send_2),
    .sfp_gled_o         (sfp_gled),
    .sfp_rled_o         (sfp_rled),
    .sfp_txflt_led_o    (sfp_txflt_led),
    .sfp_rlos_led_o     (sfp_rlos_led),
    .blink_led_o        (blink_led)
);

always #50 clk_50_pll = ~clk_50_pll;

task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first mismatch");
endtask

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run aborted");
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// strobe level after n enabled edges
function automatic logic exp_send(input int n, input int period);
    int v;
    if (n == 0)
        return 1'b0;
    v = (n - 1) % ROUND + 1;
    return (v >= period) && (v < period + 3);
endfunction

function automatic int exp_op(input int idx);
    return idx % 3;   // write out, read in, read out
endfunction

function automatic logic exp_blink(input int n);
    return ((n / BLINK_DIV) % 2) == 1;
endfunction

function automatic int strobe_code();
    if (need_write_reg_o)
        return 0;
    if (need_read_reg_i)
        return 1;
    if (need_read_reg_o)
        return 2;
    return -1;
endfunction

function automatic int bound_error_count();
    return i_dut.i_send_scheduler.i_send_asserts.error_cnt
         + i_dut.i_expander_sequencer.i_seq_asserts.error_cnt;
endfunction

always @(posedge clk_50_pll)
begin
    run_cycles++;
    if (run_cycles >= CYCLE_LIMIT)
        abort_run("timed out before all expander access rounds finished");
end

always @(posedge clk_50_pll)
begin
    if (rst_n)
    begin
        assert (cmd_send_1 == exp_send(en_cnt, SP1)) else report_mismatch("cmd_send_1 wrong");
        assert (cmd_send_2 == exp_send(en_cnt, SP2)) else report_mismatch("cmd_send_2 wrong");
        assert (blink_led == exp_blink(cycle_cnt)) else report_mismatch("blink_led wrong");
        assert (sfp_rled == ~sfp_gled) else report_mismatch("red LED not inverse of green");
        assert (sfp_txflt_led == mac_prev) else report_mismatch("txflt LED wrong");
        assert (sfp_rlos_led == rx_prev) else report_mismatch("rlos LED wrong");
        assert (bound_error_count() == 0) else abort_run("a bound protocol assertion fired");
        if (sfp_gled != gled_prev)
            gled_toggles++;
        gled_prev = sfp_gled;
        if (mac_inited && rx_ready)
            en_cnt++;
        mac_prev = mac_inited;
        rx_prev  = rx_ready;
        cycle_cnt++;
    end
end

// expander engine, answers each request with random busy time
initial
begin : engine_model
    int d_drop;
    int d_busy;
    int code;
    @(posedge rst_n);
    forever
    begin
        @(negedge clk_50_pll);
        code = strobe_code();
        if (code >= 0)
        begin
            assert (code == exp_op(op_cnt)) else report_mismatch("expander request out of order");
            assert (cycle_cnt - done_cycle >= RELAX_T) else report_mismatch("request too early");
            if (code == 0)
            begin
                assert (gled_toggles == 1) else report_mismatch("green LED toggles per round");
                gled_toggles = 0;
            end
            eng_rng = xorshift32(eng_rng);
            d_drop  = 1 + int'(eng_rng % 4);
            eng_rng = xorshift32(eng_rng);
            d_busy  = 2 + int'(eng_rng % 8);
            repeat (d_drop)
            begin
                @(negedge clk_50_pll);
                assert (strobe_code() == code) else report_mismatch("request dropped too early");
            end
            dev_ready = 1'b0;
            @(negedge clk_50_pll);
            assert (strobe_code() == -1) else report_mismatch("request held while busy");
            repeat (d_busy - 1) @(negedge clk_50_pll);
            dev_ready  = 1'b1;
            done_cycle = cycle_cnt;
            op_cnt++;
            if (code == 2)
                rounds_done++;
            // finished request echoes for one cycle as the FSM moves on
            @(negedge clk_50_pll);
        end
    end
end

initial
begin : stimulus
    int gap;
    clk_50_pll = 1'b0;
    rst_n      = 1'b0;
    mac_inited = 1'b0;
    rx_ready   = 1'b0;
    dev_ready  = 1'b1;
    repeat (8) @(negedge clk_50_pll);
    rst_n = 1'b1;
    @(posedge clk_50_pll);
    assert (strobe_code() == -1 && !cmd_send_1 && !cmd_send_2 && !blink_led && sfp_gled &&
            !i_dut.blink_tick) else report_mismatch("outputs not idle after reset");
    @(negedge clk_50_pll);
    mac_inited = 1'b1;
    rx_ready   = 1'b1;
    wait (en_cnt >= 3 * ROUND);
    wait (cmd_send_1);
    @(negedge clk_50_pll);
    stim_rng = xorshift32(stim_rng);
    gap      = 3 + int'(stim_rng % 12);
    rx_ready = 1'b0;   // freeze mid strobe
    repeat (gap) @(negedge clk_50_pll);
    rx_ready = 1'b1;
    wait (cmd_send_2);
    @(negedge clk_50_pll);
    stim_rng   = xorshift32(stim_rng);
    gap        = 3 + int'(stim_rng % 12);
    mac_inited = 1'b0;
    repeat (gap) @(negedge clk_50_pll);
    mac_inited = 1'b1;
    wait (rounds_done >= 3);
    @(negedge clk_50_pll);
    if (bound_error_count() == 0)
    begin
        $display("TB PASSED");
        $finish;
    end
    else
    begin
        abort_run("bound protocol assertions reported errors");
    end
end

endmodule

/* verilog/expander_sequencer.sv */
`timescale 1ns/100ps

module expander_sequencer
    import sfp_test_pkg::*;
#(
    parameter logic [TIMER_W-1:0] BLINK_TIME = 2000,
    parameter logic [TIMER_W-1:0] RELAX_TIME = 1500
)
(
    input  logic clk_50_pll,
    input  logic rst_n,

    input  logic dev_ready_i,

    output logic need_write_reg_o_o,
    output logic need_read_reg_i_o,
    output logic need_read_reg_o_o,

    output logic blink_tick_o
);

// recovery when the engine never comes back ready
localparam logic [TIMER_W-1:0] WAIT_WRAP  = BLINK_TIME + TIMER_W'(1000);
localparam logic [TIMER_W-1:0] RELAX_WRAP = RELAX_TIME + TIMER_W'(1000);
localparam logic [TIMER_W-1:0] BLINK_HALF = BLINK_TIME / TIMER_W'(2);

seq_state_t         state;
seq_state_t         state_next;
expander_op_t       op;

logic [TIMER_W-1:0] wait_timer;
logic [TIMER_W-1:0] relax_timer;
logic               dev_ready_prev;
logic               ready_rise;
logic               wait_done;
logic               relax_done;

assign ready_rise = dev_ready_i & ~dev_ready_prev;   // access finished
assign wait_done  = (wait_timer == BLINK_TIME) & dev_ready_i;
assign relax_done = (relax_timer == RELAX_TIME) & dev_ready_i;

always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
        dev_ready_prev <= 1'b0;
    else
        dev_ready_prev <= dev_ready_i;
end

always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
        state <= IDLE;
    else
        state <= state_next;
end

always_comb
begin
    state_next = state;
    case (state)
        IDLE:       if (dev_ready_i) state_next = WAIT_TIMER;
        WAIT_TIMER: if (wait_done)   state_next = WRITE_O;
        WRITE_O:    if (ready_rise)  state_next = RELAX_1;
        RELAX_1:    if (relax_done)  state_next = READ_I;
        READ_I:     if (ready_rise)  state_next = RELAX_2;
        RELAX_2:    if (relax_done)  state_next = READ_O;
        READ_O:     if (ready_rise)  state_next = IDLE;
        default:    state_next = IDLE;
    endcase
end

always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        wait_timer <= '0;
    end
    else if (state == WAIT_TIMER)
    begin
        if (wait_timer > WAIT_WRAP)
            wait_timer <= '0;
        else
            wait_timer <= wait_timer + TIMER_W'(1);
    end
    else
    begin
        wait_timer <= '0;
    end
end

// shared by both settle gaps, cleared during each access
always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        relax_timer <= '0;
    end
    else if (state == RELAX_1 || state == RELAX_2)
    begin
        if (relax_timer > RELAX_WRAP)
            relax_timer <= '0;
        else
            relax_timer <= relax_timer + TIMER_W'(1);
    end
    else
    begin
        relax_timer <= '0;
    end
end

always_comb
begin
    case (state)
        WRITE_O: op = OP_WRITE_OUT;
        READ_I:  op = OP_READ_IN;
        READ_O:  op = OP_READ_OUT;
        default: op = OP_NONE;
    endcase
end

// requests dropped as soon as the engine goes busy
always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        need_write_reg_o_o <= 1'b0;
        need_read_reg_i_o  <= 1'b0;
        need_read_reg_o_o  <= 1'b0;
    end
    else
    begin
        need_write_reg_o_o <= dev_ready_i & (op == OP_WRITE_OUT);
        need_read_reg_i_o  <= dev_ready_i & (op == OP_READ_IN);
        need_read_reg_o_o  <= dev_ready_i & (op == OP_READ_OUT);
    end
end

assign blink_tick_o = (state == WAIT_TIMER) & (wait_timer == BLINK_HALF);   // mid-wait

endmodule

/* verilog/health_indicator.sv */
`timescale 1ns/100ps

module health_indicator
    import sfp_test_pkg::*;
#(
    parameter logic [TIMER_W-1:0] BLINK_DIVIDE = 25000
)
(
    input  logic clk_50_pll,
    input  logic rst_n,

    input  logic blink_tick_i,
    input  logic mac_inited_i,
    input  logic rx_ready_i,

    output logic sfp_gled_o,
    output logic sfp_rled_o,
    output logic sfp_txflt_led_o,
    output logic sfp_rlos_led_o,
    output logic blink_led_o
);

logic [TIMER_W-1:0] div_cnt;

// system heartbeat
always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        div_cnt     <= '0;
        blink_led_o <= 1'b0;
    end
    else if (div_cnt == BLINK_DIVIDE - TIMER_W'(1))
    begin
        div_cnt     <= '0;
        blink_led_o <= ~blink_led_o;
    end
    else
    begin
        div_cnt <= div_cnt + TIMER_W'(1);
    end
end

always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        sfp_gled_o      <= 1'b1;   // green after reset
        sfp_txflt_led_o <= 1'b0;
        sfp_rlos_led_o  <= 1'b0;
    end
    else
    begin
        if (blink_tick_i)
            sfp_gled_o <= ~sfp_gled_o;
        sfp_txflt_led_o <= mac_inited_i;
        sfp_rlos_led_o  <= rx_ready_i;
    end
end

assign sfp_rled_o = ~sfp_gled_o;

endmodule

/* verilog/send_scheduler.sv */
`timescale 1ns/100ps

module send_scheduler
    import sfp_test_pkg::*;
#(
    parameter logic [TIMER_W-1:0] SEND_PERIOD_1 = 255,
    parameter logic [TIMER_W-1:0] SEND_PERIOD_2 = 511
)
(
    input  logic clk_50_pll,
    input  logic rst_n,

    input  logic mac_inited_i,
    input  logic rx_ready_i,

    output logic cmd_send_1_o,
    output logic cmd_send_2_o
);

localparam logic [TIMER_W-1:0] SEND_1_END = SEND_PERIOD_1 + TIMER_W'(3);
localparam logic [TIMER_W-1:0] SEND_2_END = SEND_PERIOD_2 + TIMER_W'(3);
localparam logic [TIMER_W-1:0] ROUND_END  = SEND_PERIOD_2 + TIMER_W'(10);

logic [TIMER_W-1:0] send_cnt;
logic [TIMER_W-1:0] send_cnt_inc;
logic               link_up;

assign link_up      = mac_inited_i & rx_ready_i;
assign send_cnt_inc = send_cnt + TIMER_W'(1);   // value taken at this edge

always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        send_cnt <= '0;
    end
    else if (link_up)
    begin
        if (send_cnt_inc == ROUND_END)
        begin
            send_cnt <= '0;
        end
        else
        begin
            send_cnt <= send_cnt_inc;
        end
    end
end

// strobes held while the link is down
always_ff @(posedge clk_50_pll, negedge rst_n)
begin
    if (~rst_n)
    begin
        cmd_send_1_o <= 1'b0;
        cmd_send_2_o <= 1'b0;
    end
    else if (link_up)
    begin
        if (send_cnt_inc == SEND_PERIOD_1)
            cmd_send_1_o <= 1'b1;
        else if (send_cnt_inc == SEND_1_END)
            cmd_send_1_o <= 1'b0;

        if (send_cnt_inc == SEND_PERIOD_2)
            cmd_send_2_o <= 1'b1;
        else if (send_cnt_inc == SEND_2_END)
            cmd_send_2_o <= 1'b0;   // 3 enabled cycles wide
    end
end

endmodule

/* verilog/sfp_test_pkg.sv */
package sfp_test_pkg;

    // width of every cycle counter and timing parameter
    localparam int TIMER_W = 32;

    // expander access sequence
    typedef enum logic [2:0]
    {
        IDLE,
        WAIT_TIMER,   // blink interval before each round
        WRITE_O,
        RELAX_1,
        READ_I,
        RELAX_2,
        READ_O
    } seq_state_t;

    // request to the i2c expander engine
    typedef enum logic [1:0]
    {
        OP_NONE,
        OP_WRITE_OUT, // write output register
        OP_READ_IN,   // read input register
        OP_READ_OUT   // read back output register
    } expander_op_t;

endpackage

/* verilog/sfp_test_top.sv */
`timescale 1ns/100ps

module sfp_test_top
    import sfp_test_pkg::*;
#(
    parameter logic [TIMER_W-1:0] SEND_PERIOD_1 = 255,
    parameter logic [TIMER_W-1:0] SEND_PERIOD_2 = 511,   // must exceed SEND_PERIOD_1 + 3
    parameter logic [TIMER_W-1:0] BLINK_TIME    = 2000,
    parameter logic [TIMER_W-1:0] RELAX_TIME    = 1500,
    parameter logic [TIMER_W-1:0] BLINK_DIVIDE  = 25000
)
(
    input  logic clk_50_pll,
    input  logic rst_n,

    // link status from the platform
    input  logic mac_inited_i,
    input  logic rx_ready_i,

    // expander engine conduit
    input  logic dev_ready_i,
    output logic need_write_reg_o_o,
    output logic need_read_reg_i_o,
    output logic need_read_reg_o_o,

    output logic cmd_send_1_o,
    output logic cmd_send_2_o,

    output logic sfp_gled_o,
    output logic sfp_rled_o,
    output logic sfp_txflt_led_o,
    output logic sfp_rlos_led_o,
    output logic blink_led_o
);

logic blink_tick;

send_scheduler #(
    .SEND_PERIOD_1  (SEND_PERIOD_1),
    .SEND_PERIOD_2  (SEND_PERIOD_2)
) i_send_scheduler (
    .clk_50_pll     (clk_50_pll),
    .rst_n          (rst_n),
    .mac_inited_i   (mac_inited_i),
    .rx_ready_i     (rx_ready_i),
    .cmd_send_1_o   (cmd_send_1_o),
    .cmd_send_2_o   (cmd_send_2_o)
);

expander_sequencer #(
    .BLINK_TIME         (BLINK_TIME),
    .RELAX_TIME         (RELAX_TIME)
) i_expander_sequencer (
    .clk_50_pll         (clk_50_pll),
    .rst_n              (rst_n),
    .dev_ready_i        (dev_ready_i),
    .need_write_reg_o_o (need_write_reg_o_o),
    .need_read_reg_i_o  (need_read_reg_i_o),
    .need_read_reg_o_o  (need_read_reg_o_o),
    .blink_tick_o       (blink_tick)
);

health_indicator #(
    .BLINK_DIVIDE       (BLINK_DIVIDE)
) i_health_indicator (
    .clk_50_pll         (clk_50_pll),
    .rst_n              (rst_n),
    .blink_tick_i       (blink_tick),
    .mac_inited_i       (mac_inited_i),
    .rx_ready_i         (rx_ready_i),
    .sfp_gled_o         (sfp_gled_o),
    .sfp_rled_o         (sfp_rled_o),
    .sfp_txflt_led_o    (sfp_txflt_led_o),
    .sfp_rlos_led_o     (sfp_rlos_led_o),
    .blink_led_o        (blink_led_o)
);

endmodule
